/* logic/readout_consts.svh */
// readout controller constants
// channel counts, frame widths and window offsets
`ifndef READOUT_CONSTS_SVH
`define READOUT_CONSTS_SVH

`define READOUT_CHANNELS     8
`define READOUT_WORD_BITS    120
`define READOUT_PAYLOAD_BITS 116
`define READOUT_WORD_BYTES   15
`define READOUT_SLOTS        15   // read slots per window
`define READOUT_FILL_BITS    10
`define READOUT_CYCLE_BITS   12
`define READOUT_FIFO_DEPTH   32

// offsets from the window start
`define READOUT_HOLD_FIRST   17
`define READOUT_HOLD_LAST    24
`define READOUT_CLEAR_FIRST  18
`define READOUT_CLEAR_LAST   20

`endif

/* logic/readout_pkg.sv */
// readout types
// vector widths of the frame format and the scanner state
`default_nettype none
`include "readout_consts.svh"

package readout_pkg;

	typedef logic [`READOUT_WORD_BITS-1:0]        word_t;
	typedef logic [`READOUT_CHANNELS-1:0]         chan_mask_t;  // one bit per channel
	typedef logic [$clog2(`READOUT_CHANNELS)-1:0] chan_id_t;
	typedef logic [`READOUT_PAYLOAD_BITS-1:0]     payload_t;
	typedef logic [`READOUT_FILL_BITS-1:0]        fill_t;
	typedef logic [`READOUT_CYCLE_BITS-1:0]       cycle_t;      // period position
	typedef logic [47:0]                          mac_t;
	typedef logic [7:0]                           byte_t;
	typedef logic [3:0]                           byte_idx_t;   // byte within a word

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		DONE
	} scan_state_t;

endpackage

`default_nettype wire

/* logic/frame_word_if.sv */
// frame word link
// head of the word FIFO as seen by the byte serializer
`timescale 1ns/1ps
`default_nettype none

interface frame_word_if;

	logic               avail;  // FIFO not empty
	readout_pkg::word_t word;   // head entry
	logic               last;   // head entry closes a frame
	logic               pop;    // remove head, only while avail

	modport fifo_side (output avail, output word, output last, input pop);
	modport serializer_side (input avail, input word, input last, output pop);

endinterface

`default_nettype wire

/* logic/sample_timer.sv */
// sample timer
// period counter, tick and the decode of all window phases
`timescale 1ns/1ps
`default_nettype none
`include "readout_consts.svh"

module sample_timer (
	input  wire                 clk,
	input  wire                 reset,
	input  wire readout_pkg::cycle_t counter_th,
	output logic                cycle_tick,
	output logic                window_start,
	output logic                window_slot,
	output logic                count_phase,
	output logic                hold_phase,
	output logic                clear_phase
);

	localparam readout_pkg::cycle_t SLOT_LAST   = readout_pkg::cycle_t'(`READOUT_SLOTS);
	localparam readout_pkg::cycle_t HOLD_FIRST  = readout_pkg::cycle_t'(`READOUT_HOLD_FIRST);
	localparam readout_pkg::cycle_t HOLD_LAST   = readout_pkg::cycle_t'(`READOUT_HOLD_LAST);
	localparam readout_pkg::cycle_t CLEAR_FIRST = readout_pkg::cycle_t'(`READOUT_CLEAR_FIRST);
	localparam readout_pkg::cycle_t CLEAR_LAST  = readout_pkg::cycle_t'(`READOUT_CLEAR_LAST);

	readout_pkg::cycle_t pos;    // position in the period
	readout_pkg::cycle_t start;  // window start, half the period
	readout_pkg::cycle_t rel;    // offset from the start, wraps high before it

	assign start = counter_th >> 1;
	assign rel   = pos - start;

	always_ff @(posedge clk) begin
		if (reset) begin
			pos <= '0;
		end else if (pos == counter_th) begin
			pos <= '0;
		end else begin
			pos <= pos + 1'b1;
		end
	end

	assign cycle_tick   = (pos == counter_th);
	assign window_start = (rel == '0);
	assign window_slot  = (rel != '0) && (rel <= SLOT_LAST);
	assign count_phase  = (rel == HOLD_FIRST);  // fills are taken as the hold begins
	assign hold_phase   = (rel >= HOLD_FIRST) && (rel <= HOLD_LAST);
	assign clear_phase  = (rel >= CLEAR_FIRST) && (rel <= CLEAR_LAST);

	a_start_not_slot: assert property (@(posedge clk) disable iff (reset)
		!(window_start && window_slot));

endmodule

`default_nettype wire

/* logic/channel_scanner.sv */
// channel scanner
// captures the non-empty channels and grants one read per slot, highest first
`timescale 1ns/1ps
`default_nettype none
`include "readout_consts.svh"

module channel_scanner (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     window_start,
	input  wire                     window_slot,
	input  wire readout_pkg::chan_mask_t fifo_empty,
	output readout_pkg::chan_mask_t channel_read,
	output logic                    granted,
	output readout_pkg::chan_id_t   grant_id,
	output logic                    any_pending
);

	readout_pkg::scan_state_t state;
	readout_pkg::chan_mask_t  not_empty;
	readout_pkg::chan_mask_t  pending;   // channels still owed a read
	readout_pkg::chan_mask_t  pick;      // top bit of pending
	readout_pkg::chan_id_t    pick_id;
	logic                     slot_active;

	assign not_empty   = ~fifo_empty;
	assign slot_active = (state == readout_pkg::SCAN) && window_slot;

	// later iterations overwrite, so the highest channel wins
	always_comb begin
		pick    = '0;
		pick_id = '0;
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			if (pending[i]) begin
				pick    = '0;
				pick[i] = 1'b1;
				pick_id = readout_pkg::chan_id_t'(i);
			end
		end
	end

	assign channel_read = slot_active ? pick : '0;
	assign granted      = |channel_read;
	assign grant_id     = pick_id;
	assign any_pending  = window_start ? (|not_empty) : (state == readout_pkg::SCAN);

	// ====================
	// window FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= readout_pkg::IDLE;
			pending <= '0;
		end else begin
			case (state)
				readout_pkg::IDLE: begin
					if (window_start) begin
						pending <= not_empty;
						state   <= (|not_empty) ? readout_pkg::SCAN : readout_pkg::DONE;
					end
				end
				readout_pkg::SCAN: begin
					if (window_slot) begin
						// empty slot reloads from the live flags
						pending <= (pending == '0) ? not_empty : (pending & ~pick);
					end else begin
						state <= readout_pkg::DONE;  // slots over
					end
				end
				default: begin
					pending <= '0;
					state   <= readout_pkg::IDLE;
				end
			endcase
		end
	end

	a_read_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(channel_read));

endmodule

`default_nettype wire

/* logic/frame_builder.sv */
// frame builder
// header, data and counter words of a frame, plus the hold and clear pulses
`timescale 1ns/1ps
`default_nettype none
`include "readout_consts.svh"

module frame_builder (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    window_start,
	input  wire                    count_phase,
	input  wire                    hold_phase,
	input  wire                    clear_phase,
	input  wire                    granted,
	input  wire                    any_pending,
	input  wire readout_pkg::chan_id_t grant_id,
	input  wire readout_pkg::payload_t [`READOUT_CHANNELS-1:0] channel_data,
	input  wire readout_pkg::fill_t [`READOUT_CHANNELS-1:0] channel_fill,
	input  wire readout_pkg::mac_t dest_mac,
	input  wire readout_pkg::mac_t src_mac,
	input  wire                    trigger_index,
	output logic                   word_write,
	output logic                   word_last,
	output readout_pkg::word_t     word_data,
	output logic                   hold,
	output logic                   clear
);

	localparam int PAD_BITS = `READOUT_WORD_BITS - `READOUT_CHANNELS * `READOUT_FILL_BITS;

	logic               active;        // this window sends a frame
	logic [6:0]         packet_count;
	readout_pkg::word_t header_word;
	readout_pkg::word_t data_word;
	readout_pkg::word_t count_word;

	// ====================
	// word formats
	assign header_word = {dest_mac, src_mac, trigger_index, packet_count, 8'h00, 8'hff};
	assign data_word   = {1'b1, grant_id, channel_data[grant_id]};
	assign count_word  = {channel_fill, {PAD_BITS{1'b1}}};  // channel 7 on top

	always_ff @(posedge clk) begin
		if (reset) begin
			active       <= 1'b0;
			packet_count <= '0;
			word_write   <= 1'b0;
			word_last    <= 1'b0;
			hold         <= 1'b0;
			clear        <= 1'b0;
		end else begin
			word_write <= 1'b0;
			word_last  <= 1'b0;
			if (window_start) begin
				active     <= any_pending;
				word_write <= any_pending;  // empty window is skipped
				if (any_pending) begin
					packet_count <= packet_count + 1'b1;
				end
			end else if (granted) begin
				word_write <= 1'b1;
			end else if (count_phase) begin
				word_write <= active;
				word_last  <= active;
			end
			hold  <= hold_phase & active;
			clear <= clear_phase & active;
		end
	end

	// data sampled in the cycle of its read strobe
	always_ff @(posedge clk) begin
		if (window_start) begin
			word_data <= header_word;
		end else if (granted) begin
			word_data <= data_word;
		end else if (count_phase) begin
			word_data <= count_word;
		end
	end

	a_last_with_write: assert property (@(posedge clk) disable iff (reset)
		word_last |-> word_write);

endmodule

`default_nettype wire

/* logic/word_fifo.sv */
// word FIFO
// register array of frame words and their end-of-frame flags
`timescale 1ns/1ps
`default_nettype none
`include "readout_consts.svh"

module word_fifo (
	input  wire                clk,
	input  wire                reset,
	input  wire                write,
	input  wire                last,
	input  wire readout_pkg::word_t data,
	frame_word_if.fifo_side    rd
);

	localparam int PTR_BITS = $clog2(`READOUT_FIFO_DEPTH);
	localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS + 1)'(`READOUT_FIFO_DEPTH);

	logic [`READOUT_WORD_BITS:0] mem [`READOUT_FIFO_DEPTH];  // flag above the word
	logic [PTR_BITS-1:0]         wr_ptr;
	logic [PTR_BITS-1:0]         rd_ptr;
	logic [PTR_BITS:0]           count;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd.pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({write, rd.pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // none or both
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (write) begin
			mem[wr_ptr] <= {last, data};
		end
	end

	assign rd.avail           = (count != '0);
	assign {rd.last, rd.word} = mem[rd_ptr];

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		!(write && (count == FULL_COUNT)));

endmodule

`default_nettype wire

/* logic/byte_serializer.sv */
// byte serializer
// sends each frame word as 15 bytes, top byte first, under tready back-pressure
`timescale 1ns/1ps
`default_nettype none
`include "readout_consts.svh"

module byte_serializer (
	input  wire                   clk,
	input  wire                   reset,
	frame_word_if.serializer_side rd,
	output readout_pkg::byte_t    tdata,
	output logic                  tvalid,
	output logic                  tlast,
	input  wire                   tready
);

	localparam readout_pkg::byte_idx_t LAST_BYTE =
		readout_pkg::byte_idx_t'(`READOUT_WORD_BYTES - 1);

	readout_pkg::word_t     shift;      // current word, next byte on top
	readout_pkg::byte_idx_t byte_idx;
	logic                   word_last;  // current word ends the frame
	logic                   xfer;
	logic                   word_done;

	assign xfer      = tvalid && tready;
	assign word_done = xfer && (byte_idx == LAST_BYTE);

	// fetch when idle or as the final byte leaves
	assign rd.pop = rd.avail && (!tvalid || word_done);

	assign tdata = shift[`READOUT_WORD_BITS-1 -: 8];
	assign tlast = tvalid && word_last && (byte_idx == LAST_BYTE);

	// ====================
	// byte control
	always_ff @(posedge clk) begin
		if (reset) begin
			tvalid   <= 1'b0;
			byte_idx <= '0;
		end else if (rd.pop) begin
			tvalid   <= 1'b1;
			byte_idx <= '0;
		end else if (word_done) begin
			tvalid <= 1'b0;  // FIFO ran dry
		end else if (xfer) begin
			byte_idx <= byte_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rd.pop) begin
			shift     <= rd.word;
			word_last <= rd.last;
		end else if (xfer) begin
			shift <= shift << 8;
		end
	end

	a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tlast));

endmodule

`default_nettype wire

/* logic/readout_control.sv */
// readout controller top
// timer, scanner, frame builder, word FIFO and byte serializer
`timescale 1ns/1ps
`default_nettype none
`include "readout_consts.svh"

module readout_control (
	input  wire                     clk,
	input  wire                     reset,
	input  wire readout_pkg::cycle_t counter_th,
	input  wire readout_pkg::mac_t  dest_mac,
	input  wire readout_pkg::mac_t  src_mac,
	input  wire                     trigger_index,
	input  wire readout_pkg::chan_mask_t fifo_empty,
	input  wire readout_pkg::payload_t [`READOUT_CHANNELS-1:0] channel_data,
	input  wire readout_pkg::fill_t [`READOUT_CHANNELS-1:0] channel_fill,
	output readout_pkg::chan_mask_t channel_read,
	output logic                    hold,
	output logic                    clear,
	output logic                    cycle_tick,
	output readout_pkg::byte_t      tdata,
	output logic                    tvalid,
	input  wire                     tready,
	output logic                    tlast
);

	logic                  window_start;
	logic                  window_slot;
	logic                  count_phase;
	logic                  hold_phase;
	logic                  clear_phase;
	logic                  granted;
	logic                  any_pending;
	readout_pkg::chan_id_t grant_id;
	logic                  word_write;
	logic                  word_last;
	readout_pkg::word_t    word_data;

	frame_word_if frame_rd ();  // FIFO head to serializer

	sample_timer i_timer (
		.clk          (clk),
		.reset        (reset),
		.counter_th   (counter_th),
		.cycle_tick   (cycle_tick),
		.window_start (window_start),
		.window_slot  (window_slot),
		.count_phase  (count_phase),
		.hold_phase   (hold_phase),
		.clear_phase  (clear_phase)
	);

	channel_scanner i_scanner (
		.clk          (clk),
		.reset        (reset),
		.window_start (window_start),
		.window_slot  (window_slot),
		.fifo_empty   (fifo_empty),
		.channel_read (channel_read),
		.granted      (granted),
		.grant_id     (grant_id),
		.any_pending  (any_pending)
	);

	frame_builder i_builder (
		.clk           (clk),
		.reset         (reset),
		.window_start  (window_start),
		.count_phase   (count_phase),
		.hold_phase    (hold_phase),
		.clear_phase   (clear_phase),
		.granted       (granted),
		.any_pending   (any_pending),
		.grant_id      (grant_id),
		.channel_data  (channel_data),
		.channel_fill  (channel_fill),
		.dest_mac      (dest_mac),
		.src_mac       (src_mac),
		.trigger_index (trigger_index),
		.word_write    (word_write),
		.word_last     (word_last),
		.word_data     (word_data),
		.hold          (hold),
		.clear         (clear)
	);

	word_fifo i_fifo (
		.clk   (clk),
		.reset (reset),
		.write (word_write),
		.last  (word_last),
		.data  (word_data),
		.rd    (frame_rd.fifo_side)
	);

	byte_serializer i_serializer (
		.clk    (clk),
		.reset  (reset),
		.rd     (frame_rd.serializer_side),
		.tdata  (tdata),
		.tvalid (tvalid),
		.tlast  (tlast),
		.tready (tready)
	);

endmodule

`default_nettype wire

/* tests/readout_tb.sv */
// readout controller testbench
// channel queue models, random tready, frame and byte stream checks
`timescale 1ns/1ps
`default_nettype none
`include "readout_consts.svh"

module readout_tb;

	localparam int TH           = 80;
	localparam int S            = TH >> 1;     // window start
	localparam int PERIOD       = TH + 1;
	localparam int FILL_PERIODS = 28;          // no refill after this
	localparam int RUN_PERIODS  = 30;
	localparam int LIMIT_CYCLES = 40 * PERIOD;

	logic                                           clk;
	logic                                           reset         = 1'b1;
	readout_pkg::cycle_t                            counter_th    = readout_pkg::cycle_t'(TH);
	readout_pkg::mac_t                              dest_mac      = 48'h02_00_5e_10_20_30;
	readout_pkg::mac_t                              src_mac       = 48'h02_00_5e_a0_b0_c0;
	logic                                           trigger_index = 1'b0;
	readout_pkg::chan_mask_t                        fifo_empty    = '1;
	readout_pkg::payload_t [`READOUT_CHANNELS-1:0] channel_data  = '0;
	readout_pkg::fill_t [`READOUT_CHANNELS-1:0]    channel_fill  = '0;
	logic                                           tready        = 1'b0;
	readout_pkg::chan_mask_t                        channel_read;
	logic                                           hold;
	logic                                           clear;
	logic                                           cycle_tick;
	readout_pkg::byte_t                             tdata;
	logic                                           tvalid;
	logic                                           tlast;

	// channel models and expected frame words with the flag bit on top
	readout_pkg::payload_t       chan_q [`READOUT_CHANNELS][$];
	int                          seq [`READOUT_CHANNELS];
	logic [`READOUT_WORD_BITS:0] exp_q [$];
	int                          len_q [$];   // expected frame bytes

	logic [31:0]             rng = 32'h2cc5;
	int                      reset_cycles = 0;
	int                      cycles = 0;
	int                      pos = 0;
	int                      rel = 0;
	int                      period = 0;
	int                      last_tick = -1;
	int                      n_data = 0;
	int                      exp_packet = 0;
	logic                    win_active = 1'b0;
	readout_pkg::chan_mask_t pend = '0;
	readout_pkg::word_t      word_buf = '0;
	int                      byte_cnt = 0;
	int                      frame_bytes = 0;
	logic                    stalled = 1'b0;
	readout_pkg::byte_t      held_data = '0;
	logic                    held_last = 1'b0;

	readout_control i_dut (
		.clk           (clk),
		.reset         (reset),
		.counter_th    (counter_th),
		.dest_mac      (dest_mac),
		.src_mac       (src_mac),
		.trigger_index (trigger_index),
		.fifo_empty    (fifo_empty),
		.channel_data  (channel_data),
		.channel_fill  (channel_fill),
		.channel_read  (channel_read),
		.hold          (hold),
		.clear         (clear),
		.cycle_tick    (cycle_tick),
		.tdata         (tdata),
		.tvalid        (tvalid),
		.tready        (tready),
		.tlast         (tlast)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ====================
	// helpers
	task automatic end_with_errors();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic show_mismatch(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		$display("Fail %s expected %0h actual %0h", name, expected, actual);
		end_with_errors();
	endtask

	task automatic plain_failure(input string msg);
		$display("%s", msg);
		end_with_errors();
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			rng = lfsr_next(rng);  // one step per bit
			v = (v << 1) | int'(rng[0]);
		end
	endtask

	function automatic int top_channel(input readout_pkg::chan_mask_t m);
		int c;
		c = -1;
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			if (m[i]) begin
				c = i;
			end
		end
		return c;
	endfunction

	function automatic readout_pkg::payload_t payload_for(input int c, input int n);
		readout_pkg::payload_t p;
		p = '0;
		p[115:108] = 8'(c);
		p[31:0]    = n;
		return p;
	endfunction

	// ====================
	// checks
	task automatic check_timer();
		a_tick: assert (cycle_tick == (pos == TH))
			else show_mismatch("cycle_tick", 128'(pos == TH), 128'(cycle_tick));
		if (cycle_tick) begin
			if (last_tick >= 0) begin
				a_tick_gap: assert (cycles - last_tick == PERIOD)
					else show_mismatch("tick_spacing", 128'(PERIOD), 128'(cycles - last_tick));
			end
			last_tick = cycles;
		end
	endtask

	task automatic check_pulses();
		logic exp_hold;
		logic exp_clear;
		// registered pulses lag the phase by one cycle
		exp_hold  = win_active && rel > `READOUT_HOLD_FIRST && rel <= `READOUT_HOLD_LAST + 1;
		exp_clear = win_active && rel > `READOUT_CLEAR_FIRST && rel <= `READOUT_CLEAR_LAST + 1;
		a_hold: assert (hold == exp_hold)
			else show_mismatch("hold", 128'(exp_hold), 128'(hold));
		a_clear: assert (clear == exp_clear)
			else show_mismatch("clear", 128'(exp_clear), 128'(clear));
	endtask

	task automatic model_window();
		readout_pkg::chan_mask_t exp_read;
		int                      c;
		exp_read = '0;
		if (rel == 0) begin
			pend       = ~fifo_empty;
			win_active = (pend != '0);
			n_data     = 0;
			if (win_active) begin
				exp_q.push_back({1'b0, dest_mac, src_mac, trigger_index, 7'(exp_packet),
					8'h00, 8'hff});
				exp_packet++;
			end
		end else if (win_active && rel >= 1 && rel <= `READOUT_SLOTS) begin
			c = top_channel(pend);
			if (c < 0) begin
				pend = ~fifo_empty;  // idle slot, reload
			end else begin
				exp_read[c] = 1'b1;
				pend[c]     = 1'b0;
			end
		end else if (win_active && rel == `READOUT_HOLD_FIRST) begin
			exp_q.push_back({1'b1, channel_fill, 40'hff_ffff_ffff});
			len_q.push_back((n_data + 2) * `READOUT_WORD_BYTES);
		end
		a_read_onehot: assert ($onehot0(channel_read))
			else plain_failure("channel_read has more than one channel set");
		a_read: assert (channel_read == exp_read)
			else show_mismatch("channel_read", 128'(exp_read), 128'(channel_read));
		c = top_channel(channel_read);
		if (c >= 0) begin
			exp_q.push_back({1'b0, 1'b1, 3'(c), chan_q[c][0]});
			void'(chan_q[c].pop_front());
			n_data++;
		end
	endtask

	task automatic monitor_bytes();
		logic [`READOUT_WORD_BITS:0] e;
		if (stalled) begin
			a_stall_valid: assert (tvalid)
				else plain_failure("tvalid dropped while the byte was stalled");
			a_stall_data: assert (tdata == held_data)
				else show_mismatch("tdata_stall", 128'(held_data), 128'(tdata));
			a_stall_last: assert (tlast == held_last)
				else show_mismatch("tlast_stall", 128'(held_last), 128'(tlast));
		end
		stalled   = tvalid && !tready;
		held_data = tdata;
		held_last = tlast;
		if (tvalid && tready) begin
			word_buf = {word_buf[`READOUT_WORD_BITS-9:0], tdata};
			byte_cnt++;
			frame_bytes++;
			if (byte_cnt < `READOUT_WORD_BYTES) begin
				a_tlast_mid: assert (!tlast)
					else plain_failure("tlast high in the middle of a word");
			end else begin
				a_word_expected: assert (exp_q.size() != 0)
					else plain_failure("a word was sent with no frame word expected");
				byte_cnt = 0;
				e = exp_q.pop_front();
				a_word: assert (word_buf == e[`READOUT_WORD_BITS-1:0])
					else show_mismatch("frame_word", 128'(e[`READOUT_WORD_BITS-1:0]),
						128'(word_buf));
				a_tlast: assert (tlast == e[`READOUT_WORD_BITS])
					else show_mismatch("tlast", 128'(e[`READOUT_WORD_BITS]), 128'(tlast));
				if (tlast) begin
					a_length: assert (frame_bytes == len_q[0])
						else show_mismatch("frame_length", 128'(len_q[0]), 128'(frame_bytes));
					void'(len_q.pop_front());
					frame_bytes = 0;
				end
			end
		end
	endtask

	task automatic refill_channels();
		int v;
		int n;
		for (int c = 0; c < `READOUT_CHANNELS; c++) begin
			draw_bits(2, v);
			n = (v & 1) + (v >> 1);  // 0 to 2 new entries
			for (int k = 0; k < n; k++) begin
				chan_q[c].push_back(payload_for(c, seq[c]));
				seq[c]++;
			end
		end
	endtask

	// ====================
	// main loop samples outputs before the edge updates them
	always @(posedge clk) begin : bench
		int bits;
		if (reset) begin
			reset_cycles++;
			if (reset_cycles == 16) begin
				reset <= 1'b0;
			end
		end else begin
			rel = pos - S;
			check_timer();
			check_pulses();
			model_window();
			monitor_bytes();
			if (pos == 0 && period % 4 == 0 && period < FILL_PERIODS) begin
				refill_channels();
			end
			if (pos == TH) begin
				pos = 0;
				period++;
			end else begin
				pos++;
			end
			cycles++;

			trigger_index <= 1'(period % 2);
			for (int c = 0; c < `READOUT_CHANNELS; c++) begin
				fifo_empty[c]   <= (chan_q[c].size() == 0);
				channel_data[c] <= (chan_q[c].size() != 0) ? chan_q[c][0] : '0;
				channel_fill[c] <= readout_pkg::fill_t'(chan_q[c].size());
			end
			draw_bits(3, bits);
			tready <= (bits != 7);  // stall one cycle in eight

			if (period >= RUN_PERIODS && exp_q.size() == 0 && !tvalid) begin
				$display("Finished with no errors");
				$finish;
			end else if (cycles >= LIMIT_CYCLES) begin
				plain_failure("run did not finish within the cycle limit");
			end
		end
	end

endmodule

`default_nettype wire

/* readout.f */
+incdir+logic
logic/readout_pkg.sv
logic/frame_word_if.sv
logic/sample_timer.sv
logic/channel_scanner.sv
logic/frame_builder.sv
logic/word_fifo.sv
logic/byte_serializer.sv
logic/readout_control.sv
tests/readout_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the readout testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f readout.f --top-module readout_tb -o readout_sim

out=$(./obj_dir/readout_sim 2>&1) || true
echo "$out"
if grep -qx "Finished with no errors" <<< "$out"; then
	exit 0
fi
exit 1
